/* design/npc_settings.svh */
`ifndef NPC_SETTINGS_SVH
`define NPC_SETTINGS_SVH

// first fetch address after start
`define NPC_RESET_PC 32'h80000000

// instruction memory depth and word-index width
`define NPC_IMEM_WORDS 256
`define NPC_IMEM_AW 8

// data memory depth and word-index width
`define NPC_DMEM_WORDS 256
`define NPC_DMEM_AW 8

`endif

/* design/npc_pkg.sv */
package npc_pkg;

    // major opcodes of the supported RV32I subset
    typedef enum logic [6:0] {
        OP_LUI    = 7'b0110111,
        OP_AUIPC  = 7'b0010111,
        OP_JAL    = 7'b1101111,
        OP_JALR   = 7'b1100111,
        OP_OP_IMM = 7'b0010011,
        OP_OP     = 7'b0110011,
        OP_LOAD   = 7'b0000011,
        OP_STORE  = 7'b0100011,
        OP_SYSTEM = 7'b1110011
    } opcode_e;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_RUN,
        ST_MEM_WAIT,
        ST_HALT
    } core_state_e;

    // writeback source
    typedef enum logic [1:0] {
        WB_ALU,
        WB_MEM,
        WB_PC4,
        WB_IMM
    } wb_sel_e;

    typedef enum logic {
        SZ_BYTE,
        SZ_WORD
    } mem_size_e;

    typedef struct packed {
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [31:0] imm;
        logic        reg_wen;
        logic        src1_is_pc;
        logic        src2_is_imm;
        logic        is_load;
        logic        is_store;
        logic        is_jal;
        logic        is_jalr;
        logic        is_ebreak;
        logic        illegal;
        wb_sel_e     wb_sel;
        mem_size_e   size;
    } decoded_t;

endpackage

/* design/npc_mem_if.sv */
interface npc_mem_if;

    // request channel
    logic        req_valid;
    logic        req_ready;
    logic        req_we;
    logic [31:0] req_addr;
    logic [31:0] req_wdata;
    logic [3:0]  req_wmask;

    // response, one per accepted request
    logic        rsp_valid;
    logic [31:0] rsp_rdata;

    modport lsu (
        output req_valid, req_we, req_addr, req_wdata, req_wmask,
        input  req_ready, rsp_valid, rsp_rdata
    );

    modport mem (
        input  req_valid, req_we, req_addr, req_wdata, req_wmask,
        output req_ready, rsp_valid, rsp_rdata
    );

endinterface

/* design/npc_inst_mem.sv */
`include "npc_settings.svh"

module npc_inst_mem (
    input  logic                    clk,
    input  logic                    load_valid,
    input  logic                    load_ready,
    input  logic [`NPC_IMEM_AW-1:0] load_addr,
    input  logic [31:0]             load_data,
    input  logic [31:0]             fetch_addr,
    output logic [31:0]             fetch_data
);

    logic [31:0] words [`NPC_IMEM_WORDS];
    logic [`NPC_IMEM_AW-1:0] fetch_idx;

    // host writes only on the load handshake
    always_ff @(posedge clk) begin
        if (load_valid && load_ready) begin
            words[load_addr] <= load_data;
        end
    end

    // byte address folded onto the word array
    assign fetch_idx = fetch_addr[`NPC_IMEM_AW+1:2];

    assign fetch_data = words[fetch_idx];

endmodule

/* design/npc_decoder.sv */
module npc_decoder (
    input  logic [31:0]       inst,
    output npc_pkg::decoded_t dec
);

    npc_pkg::opcode_e opcode;
    logic [2:0]       funct3;
    logic [6:0]       funct7;
    logic [31:0]      imm_i;
    logic [31:0]      imm_s;
    logic [31:0]      imm_u;
    logic [31:0]      imm_j;

    assign opcode = npc_pkg::opcode_e'(inst[6:0]);
    assign funct3 = inst[14:12];
    assign funct7 = inst[31:25];

    // all immediates sign extended up front
    assign imm_i = {{20{inst[31]}}, inst[31:20]};
    assign imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
    assign imm_u = {inst[31:12], 12'b0};
    assign imm_j = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

    always_comb begin
        dec     = '0;
        dec.rd  = inst[11:7];
        dec.rs1 = inst[19:15];
        dec.rs2 = inst[24:20];

        case (opcode)
            npc_pkg::OP_LUI: begin
                dec.imm     = imm_u;
                dec.reg_wen = 1'b1;
                dec.wb_sel  = npc_pkg::WB_IMM;
            end
            npc_pkg::OP_AUIPC: begin
                dec.imm         = imm_u;
                dec.reg_wen     = 1'b1;
                dec.src1_is_pc  = 1'b1;
                dec.src2_is_imm = 1'b1;
            end
            npc_pkg::OP_JAL: begin
                dec.imm     = imm_j;
                dec.reg_wen = 1'b1;
                dec.is_jal  = 1'b1;
                dec.wb_sel  = npc_pkg::WB_PC4;
            end
            npc_pkg::OP_JALR: begin
                dec.imm = imm_i;
                if (funct3 == 3'b000) begin
                    dec.reg_wen = 1'b1;
                    dec.is_jalr = 1'b1;
                    dec.wb_sel  = npc_pkg::WB_PC4;
                end else begin
                    dec.illegal = 1'b1;
                end
            end
            npc_pkg::OP_OP_IMM: begin
                // addi only
                dec.imm = imm_i;
                if (funct3 == 3'b000) begin
                    dec.reg_wen     = 1'b1;
                    dec.src2_is_imm = 1'b1;
                end else begin
                    dec.illegal = 1'b1;
                end
            end
            npc_pkg::OP_OP: begin
                // add only with funct7 zero
                if (funct3 == 3'b000 && funct7 == 7'b0) begin
                    dec.reg_wen = 1'b1;
                end else begin
                    dec.illegal = 1'b1;
                end
            end
            npc_pkg::OP_LOAD: begin
                dec.imm = imm_i;
                if (funct3 == 3'b010 || funct3 == 3'b100) begin
                    dec.reg_wen = 1'b1;
                    dec.is_load = 1'b1;
                    dec.wb_sel  = npc_pkg::WB_MEM;
                    dec.size    = (funct3 == 3'b010) ? npc_pkg::SZ_WORD : npc_pkg::SZ_BYTE;
                end else begin
                    dec.illegal = 1'b1;
                end
            end
            npc_pkg::OP_STORE: begin
                dec.imm = imm_s;
                if (funct3 == 3'b010 || funct3 == 3'b000) begin
                    dec.is_store = 1'b1;
                    dec.size     = (funct3 == 3'b010) ? npc_pkg::SZ_WORD : npc_pkg::SZ_BYTE;
                end else begin
                    dec.illegal = 1'b1;
                end
            end
            npc_pkg::OP_SYSTEM: begin
                // the whole word has to match ebreak
                if (inst == 32'h00100073) begin
                    dec.is_ebreak = 1'b1;
                end else begin
                    dec.illegal = 1'b1;
                end
            end
            default: begin
                dec.illegal = 1'b1;
            end
        endcase
    end

endmodule

/* design/npc_regfile.sv */
module npc_regfile (
    input  logic        clk,
    input  logic        reset,
    input  logic        wen,
    input  logic [4:0]  waddr,
    input  logic [31:0] wdata,
    input  logic [4:0]  raddr1,
    input  logic [4:0]  raddr2,
    output logic [31:0] rdata1,
    output logic [31:0] rdata2
);

    logic [31:0] regs [32];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= 32'b0;
            end
        end else if (wen && waddr != 5'd0) begin
            regs[waddr] <= wdata;
        end
    end

    // x0 always reads zero
    assign rdata1 = (raddr1 == 5'd0) ? 32'b0 : regs[raddr1];
    assign rdata2 = (raddr2 == 5'd0) ? 32'b0 : regs[raddr2];

endmodule

/* design/npc_lsu.sv */
module npc_lsu (
    input  logic               clk,
    input  logic               reset,
    input  logic               issue,
    input  logic               is_store,
    input  npc_pkg::mem_size_e size,
    input  logic [31:0]        addr,
    input  logic [31:0]        store_data,
    output logic               busy,
    output logic               done,
    output logic [31:0]        load_data,
    npc_mem_if.lsu             mem
);

    logic               accept;
    logic               outstanding;
    logic [1:0]         lane;
    logic [1:0]         lane_q;
    npc_pkg::mem_size_e size_q;
    logic [7:0]         rsp_byte;

    assign lane = addr[1:0];

    // request fields follow the core, which holds the instruction until accepted
    assign mem.req_valid = issue;
    assign mem.req_we    = is_store;
    assign mem.req_addr  = {addr[31:2], 2'b00};
    assign mem.req_wmask = (size == npc_pkg::SZ_WORD) ? 4'b1111 : (4'b0001 << lane);
    assign mem.req_wdata = (size == npc_pkg::SZ_WORD) ? store_data
                                                       : ({24'b0, store_data[7:0]} << {lane, 3'b000});

    assign accept = mem.req_valid && mem.req_ready;

    always_ff @(posedge clk) begin
        if (reset) begin
            outstanding <= 1'b0;
        end else if (accept) begin
            outstanding <= 1'b1;
        end else if (mem.rsp_valid) begin
            outstanding <= 1'b0;
        end
    end

    // lane and size kept for the response
    always_ff @(posedge clk) begin
        if (accept) begin
            lane_q <= lane;
            size_q <= size;
        end
    end

    // stalled request or response still due
    assign busy = outstanding || (issue && !mem.req_ready);
    assign done = mem.rsp_valid;

    assign rsp_byte  = mem.rsp_rdata[{lane_q, 3'b000} +: 8];
    assign load_data = (size_q == npc_pkg::SZ_WORD) ? mem.rsp_rdata : {24'b0, rsp_byte};

endmodule

/* design/npc_data_mem.sv */
`include "npc_settings.svh"

module npc_data_mem (
    input  logic   clk,
    input  logic   reset,
    npc_mem_if.mem mem
);

    logic [31:0]             ram [`NPC_DMEM_WORDS];
    logic [`NPC_DMEM_AW-1:0] idx;
    logic                    pending;
    logic                    accept;
    logic [31:0]             rdata_q;

    assign idx    = mem.req_addr[`NPC_DMEM_AW+1:2];
    assign accept = mem.req_valid && mem.req_ready;

    // one request in flight at a time
    always_ff @(posedge clk) begin
        if (reset) begin
            pending <= 1'b0;
        end else begin
            pending <= accept;
        end
    end

    // writes return the word as it was before the write
    always_ff @(posedge clk) begin
        if (accept) begin
            rdata_q <= ram[idx];
            if (mem.req_we) begin
                for (int b = 0; b < 4; b++) begin
                    if (mem.req_wmask[b]) begin
                        ram[idx][8*b +: 8] <= mem.req_wdata[8*b +: 8];
                    end
                end
            end
        end
    end

    assign mem.req_ready = !pending;
    assign mem.rsp_valid = pending;
    assign mem.rsp_rdata = rdata_q;

endmodule

/* design/npc_core.sv */
`include "npc_settings.svh"

module npc_core (
    input  logic        clk,
    input  logic        reset,
    input  logic        start,
    output logic [31:0] fetch_addr,
    input  logic [31:0] fetch_data,
    output logic        load_ready,
    output logic        retire_valid,
    output logic [31:0] retire_pc,
    output logic        retire_wen,
    output logic [4:0]  retire_rd,
    output logic [31:0] retire_wdata,
    output logic        halted,
    output logic        illegal,
    output logic [31:0] halt_pc,
    npc_mem_if.lsu      mem
);

    npc_pkg::core_state_e state;
    npc_pkg::decoded_t    dec;

    logic [31:0] pc;
    logic [31:0] next_pc;
    logic [31:0] pc_plus4;
    logic [31:0] rs1_val;
    logic [31:0] rs2_val;
    logic [31:0] alu_src1;
    logic [31:0] alu_src2;
    logic [31:0] alu_sum;
    logic [31:0] base_plus_imm;
    logic [31:0] wb_data;
    logic [31:0] lsu_load_data;
    logic        lsu_busy;
    logic        lsu_done;
    logic        is_mem;
    logic        running;
    logic        halt_now;

    assign fetch_addr = pc;

    npc_decoder u_decoder (
        .inst (fetch_data),
        .dec  (dec)
    );

    npc_regfile u_regfile (
        .clk    (clk),
        .reset  (reset),
        .wen    (retire_valid && dec.reg_wen),
        .waddr  (dec.rd),
        .wdata  (wb_data),
        .raddr1 (dec.rs1),
        .raddr2 (dec.rs2),
        .rdata1 (rs1_val),
        .rdata2 (rs2_val)
    );

    assign running  = (state == npc_pkg::ST_RUN);
    assign is_mem   = dec.is_load || dec.is_store;
    assign halt_now = running && (dec.is_ebreak || dec.illegal);

    // adder shared by jalr targets and load/store addresses
    assign base_plus_imm = rs1_val + dec.imm;

    npc_lsu u_lsu (
        .clk        (clk),
        .reset      (reset),
        .issue      (running && is_mem),
        .is_store   (dec.is_store),
        .size       (dec.size),
        .addr       (base_plus_imm),
        .store_data (rs2_val),
        .busy       (lsu_busy),
        .done       (lsu_done),
        .load_data  (lsu_load_data),
        .mem        (mem)
    );

    // the only alu operation is add
    assign alu_src1 = dec.src1_is_pc ? pc : rs1_val;
    assign alu_src2 = dec.src2_is_imm ? dec.imm : rs2_val;
    assign alu_sum  = alu_src1 + alu_src2;

    assign pc_plus4 = pc + 32'd4;
    assign next_pc  = dec.is_jalr ? {base_plus_imm[31:1], 1'b0} :
                      dec.is_jal  ? pc + dec.imm :
                      pc_plus4;

    always_comb begin
        case (dec.wb_sel)
            npc_pkg::WB_MEM: wb_data = lsu_load_data;
            npc_pkg::WB_PC4: wb_data = pc_plus4;
            npc_pkg::WB_IMM: wb_data = dec.imm;
            default:         wb_data = alu_sum;
        endcase
    end

    // loads and stores retire on the response and everything else in ST_RUN
    assign retire_valid = (running && !is_mem && !halt_now)
                       || (state == npc_pkg::ST_MEM_WAIT && lsu_done);
    assign retire_pc    = pc;
    assign retire_wen   = dec.reg_wen;
    assign retire_rd    = dec.rd;
    assign retire_wdata = wb_data;

    assign load_ready = (state == npc_pkg::ST_IDLE) || (state == npc_pkg::ST_HALT);

    always_ff @(posedge clk) begin
        if (reset) begin
            state   <= npc_pkg::ST_IDLE;
            pc      <= `NPC_RESET_PC;
            halted  <= 1'b0;
            illegal <= 1'b0;
            halt_pc <= 32'b0;
        end else begin
            case (state)
                npc_pkg::ST_RUN: begin
                    if (halt_now) begin
                        state   <= npc_pkg::ST_HALT;
                        halted  <= 1'b1;
                        illegal <= dec.illegal;
                        halt_pc <= pc;
                    end else if (is_mem) begin
                        // stay here until the request is taken
                        if (!lsu_busy) begin
                            state <= npc_pkg::ST_MEM_WAIT;
                        end
                    end else begin
                        pc <= next_pc;
                    end
                end
                npc_pkg::ST_MEM_WAIT: begin
                    if (lsu_done) begin
                        pc    <= next_pc;
                        state <= npc_pkg::ST_RUN;
                    end
                end
                default: begin
                    // start from idle or halt restarts at the reset pc
                    if (start) begin
                        state   <= npc_pkg::ST_RUN;
                        pc      <= `NPC_RESET_PC;
                        halted  <= 1'b0;
                        illegal <= 1'b0;
                    end
                end
            endcase
        end
    end

endmodule

/* design/npc_top.sv */
`include "npc_settings.svh"

module npc_top (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    start,
    input  logic                    load_valid,
    output logic                    load_ready,
    input  logic [`NPC_IMEM_AW-1:0] load_addr,
    input  logic [31:0]             load_data,
    output logic                    retire_valid,
    output logic [31:0]             retire_pc,
    output logic                    retire_wen,
    output logic [4:0]              retire_rd,
    output logic [31:0]             retire_wdata,
    output logic                    halted,
    output logic                    illegal,
    output logic [31:0]             halt_pc
);

    logic [31:0] fetch_addr;
    logic [31:0] fetch_data;

    npc_mem_if mem_bus ();

    npc_inst_mem u_inst_mem (
        .clk        (clk),
        .load_valid (load_valid),
        .load_ready (load_ready),
        .load_addr  (load_addr),
        .load_data  (load_data),
        .fetch_addr (fetch_addr),
        .fetch_data (fetch_data)
    );

    npc_core u_core (
        .clk          (clk),
        .reset        (reset),
        .start        (start),
        .fetch_addr   (fetch_addr),
        .fetch_data   (fetch_data),
        .load_ready   (load_ready),
        .retire_valid (retire_valid),
        .retire_pc    (retire_pc),
        .retire_wen   (retire_wen),
        .retire_rd    (retire_rd),
        .retire_wdata (retire_wdata),
        .halted       (halted),
        .illegal      (illegal),
        .halt_pc      (halt_pc),
        .mem          (mem_bus.lsu)
    );

    npc_data_mem u_data_mem (
        .clk   (clk),
        .reset (reset),
        .mem   (mem_bus.mem)
    );

endmodule

/* sim/npc_assertions.sv */
module npc_assertions (
    input logic        clk,
    input logic        reset,
    input logic        start,
    input logic        load_ready,
    input logic        retire_valid,
    input logic [4:0]  retire_rd,
    input logic        halted,
    input logic        req_valid,
    input logic        req_ready,
    input logic        req_we,
    input logic [31:0] req_addr,
    input logic [31:0] req_wdata,
    input logic [3:0]  req_wmask,
    input logic        rsp_valid,
    input logic [31:0] x0_value
);

    int   failures = 0;
    logic accept;

    assign accept = req_valid && req_ready;

    // host port is refused while instructions execute
    a_load_refused: assert property (@(posedge clk) disable iff (reset)
        (retire_valid || req_valid) |-> !load_ready)
        else begin
            $error("load_ready high while the core runs");
            failures = failures + 1;
        end

    a_rsp_follows: assert property (@(posedge clk) disable iff (reset)
        accept |=> rsp_valid)
        else begin
            $error("no response one cycle after an accepted request");
            failures = failures + 1;
        end

    a_rsp_only_after_accept: assert property (@(posedge clk) disable iff (reset)
        rsp_valid |-> $past(accept))
        else begin
            $error("response without an accepted request");
            failures = failures + 1;
        end

    // back-pressure keeps the request unchanged
    a_req_hold: assert property (@(posedge clk) disable iff (reset)
        (req_valid && !req_ready) |=> (req_valid && $stable(req_we) && $stable(req_addr)
            && $stable(req_wdata) && $stable(req_wmask)))
        else begin
            $error("request changed before it was accepted");
            failures = failures + 1;
        end

    a_x0_zero: assert property (@(posedge clk) disable iff (reset)
        (retire_valid && retire_rd == 5'd0) |=> (x0_value == 32'b0))
        else begin
            $error("x0 holds a nonzero value");
            failures = failures + 1;
        end

    // only start clears halted
    a_halt_sticky: assert property (@(posedge clk) disable iff (reset)
        (halted && !start) |=> halted)
        else begin
            $error("halted dropped without start");
            failures = failures + 1;
        end

    a_no_retire_halted: assert property (@(posedge clk) disable iff (reset)
        halted |-> !retire_valid)
        else begin
            $error("retire while halted");
            failures = failures + 1;
        end

endmodule

bind npc_top npc_assertions u_assertions (
    .clk          (clk),
    .reset        (reset),
    .start        (start),
    .load_ready   (load_ready),
    .retire_valid (retire_valid),
    .retire_rd    (retire_rd),
    .halted       (halted),
    .req_valid    (mem_bus.req_valid),
    .req_ready    (mem_bus.req_ready),
    .req_we       (mem_bus.req_we),
    .req_addr     (mem_bus.req_addr),
    .req_wdata    (mem_bus.req_wdata),
    .req_wmask    (mem_bus.req_wmask),
    .rsp_valid    (mem_bus.rsp_valid),
    .x0_value     (u_core.u_regfile.regs[0])
);

/* sim/npc_tb.sv */
`include "npc_settings.svh"

module npc_tb;

    localparam logic [31:0] RESET_PC   = `NPC_RESET_PC;
    localparam int          TIMEOUT    = 2000;
    localparam logic [6:0]  OPC_LUI    = 7'b0110111;
    localparam logic [6:0]  OPC_AUIPC  = 7'b0010111;
    localparam logic [6:0]  OPC_JALR   = 7'b1100111;
    localparam logic [6:0]  OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0]  OPC_LOAD   = 7'b0000011;
    localparam logic [31:0] EBREAK     = 32'h00100073;
    // opcode 7'h7f lies outside the subset
    localparam logic [31:0] BAD_WORD   = 32'hffffffff;

    logic                    clk;
    logic                    reset;
    logic                    start;
    logic                    load_valid;
    logic                    load_ready;
    logic [`NPC_IMEM_AW-1:0] load_addr;
    logic [31:0]             load_data;
    logic                    retire_valid;
    logic [31:0]             retire_pc;
    logic                    retire_wen;
    logic [4:0]              retire_rd;
    logic [31:0]             retire_wdata;
    logic                    halted;
    logic                    illegal;
    logic [31:0]             halt_pc;

    logic [31:0] prog [$];
    logic [31:0] exp_pc [$];
    logic [31:0] exp_wen [$];
    logic [31:0] exp_rd [$];
    logic [31:0] exp_wdata [$];
    logic [31:0] got_pc [$];
    logic [31:0] got_wen [$];
    logic [31:0] got_rd [$];
    logic [31:0] got_wdata [$];
    int          test_errors;
    int          total_errors;
    int          tests_run;
    int          tests_failed;

    npc_top dut0 (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    function automatic logic [31:0] encode_i(input logic [6:0] op, input logic [2:0] f3,
                                             input logic [4:0] rd, input logic [4:0] rs1,
                                             input logic [11:0] imm);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] encode_s(input logic [2:0] f3, input logic [4:0] rs2,
                                             input logic [4:0] rs1, input logic [11:0] imm);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], 7'b0100011};
    endfunction

    function automatic logic [31:0] encode_u(input logic [6:0] op, input logic [4:0] rd,
                                             input logic [19:0] imm);
        return {imm, rd, op};
    endfunction

    function automatic logic [31:0] encode_jal(input logic [4:0] rd, input logic [20:0] imm);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
    endfunction

    function automatic logic [31:0] encode_add(input logic [4:0] rd, input logic [4:0] rs1,
                                               input logic [4:0] rs2);
        return {7'b0, rs2, rs1, 3'b000, rd, 7'b0110011};
    endfunction

    task automatic check_value(input string name, input string what,
                               input logic [31:0] expected, input logic [31:0] actual);
        if (expected !== actual) begin
            $display("[FAIL] %s %s: expected %h, actual %h", name, what, expected, actual);
            test_errors++;
        end
    endtask

    task automatic note_error(input string name, input string text);
        $display("test %s: %s", name, text);
        test_errors++;
    endtask

    task automatic expect_retire(input logic [31:0] pc, input logic [31:0] wen,
                                 input logic [31:0] rd, input logic [31:0] wdata);
        exp_pc.push_back(pc);
        exp_wen.push_back(wen);
        exp_rd.push_back(rd);
        exp_wdata.push_back(wdata);
    endtask

    // each word is taken at the rising edge after load_ready is seen high
    task automatic load_program(input string name);
        int cycles;
        for (int i = 0; i < prog.size(); i++) begin
            @(negedge clk);
            load_valid = 1'b1;
            load_addr  = i[`NPC_IMEM_AW-1:0];
            load_data  = prog[i];
            cycles     = 0;
            while (!load_ready && cycles < TIMEOUT) begin
                @(negedge clk);
                cycles++;
            end
            if (!load_ready) begin
                note_error(name, "load port never became ready");
            end
        end
        @(negedge clk);
        load_valid = 1'b0;
    endtask

    // pulse start, then collect retires until halted
    task automatic run_program(input string name);
        int cycles;
        @(negedge clk);
        start = 1'b1;
        @(negedge clk);
        start  = 1'b0;
        cycles = 0;
        while (!halted && cycles < TIMEOUT) begin
            if (retire_valid) begin
                got_pc.push_back(retire_pc);
                got_wen.push_back(32'(retire_wen));
                got_rd.push_back(32'(retire_rd));
                got_wdata.push_back(retire_wdata);
            end
            @(negedge clk);
            cycles++;
        end
        if (!halted) begin
            note_error(name, "timed out waiting for the core to halt");
        end
        repeat (3) begin
            @(negedge clk);
            if (retire_valid) begin
                note_error(name, "an instruction retired after the halt");
            end
        end
    endtask

    task automatic compare_trace(input string name);
        check_value(name, "retire count", exp_pc.size(), got_pc.size());
        for (int i = 0; i < exp_pc.size() && i < got_pc.size(); i++) begin
            check_value(name, $sformatf("retire %0d pc", i), exp_pc[i], got_pc[i]);
            check_value(name, $sformatf("retire %0d wen", i), exp_wen[i], got_wen[i]);
            // rd and data only mean something when the register is written
            if (exp_wen[i] == 32'd1) begin
                check_value(name, $sformatf("retire %0d rd", i), exp_rd[i], got_rd[i]);
                check_value(name, $sformatf("retire %0d wdata", i), exp_wdata[i], got_wdata[i]);
            end
        end
    endtask

    task automatic execute(input string name, input logic exp_illegal,
                           input logic [31:0] exp_halt_pc);
        load_program(name);
        run_program(name);
        compare_trace(name);
        check_value(name, "halted", 32'd1, 32'(halted));
        check_value(name, "illegal", 32'(exp_illegal), 32'(illegal));
        check_value(name, "halt_pc", exp_halt_pc, halt_pc);
        tests_run++;
        if (test_errors == 0) begin
            $display("test %s: ok", name);
        end else begin
            $display("test %s: %0d errors", name, test_errors);
            tests_failed++;
        end
        total_errors += test_errors;
        test_errors = 0;
        prog.delete();
        exp_pc.delete();
        exp_wen.delete();
        exp_rd.delete();
        exp_wdata.delete();
        got_pc.delete();
        got_wen.delete();
        got_rd.delete();
        got_wdata.delete();
    endtask

    initial begin
        reset        = 1'b1;
        start        = 1'b0;
        load_valid   = 1'b0;
        load_addr    = '0;
        load_data    = 32'b0;
        test_errors  = 0;
        total_errors = 0;
        tests_run    = 0;
        tests_failed = 0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        prog.push_back(encode_i(OPC_OP_IMM, 3'b000, 1, 0, 12'd5));
        prog.push_back(EBREAK);
        expect_retire(RESET_PC, 1, 1, 5);
        execute("load_fetch", 1'b0, RESET_PC + 4);

        // loaded while halted and x1 survives the restart
        prog.push_back(encode_i(OPC_OP_IMM, 3'b000, 1, 1, 12'd7));
        prog.push_back(EBREAK);
        expect_retire(RESET_PC, 1, 1, 12);
        execute("restart", 1'b0, RESET_PC + 4);

        prog.push_back(encode_u(OPC_LUI, 2, 20'h12345));
        prog.push_back(encode_u(OPC_AUIPC, 3, 20'h00010));
        prog.push_back(encode_i(OPC_OP_IMM, 3'b000, 4, 0, -12'd20));
        prog.push_back(encode_add(5, 2, 4));
        prog.push_back(EBREAK);
        expect_retire(RESET_PC, 1, 2, 32'h12345000);
        expect_retire(RESET_PC + 4, 1, 3, RESET_PC + 4 + 32'h00010000);
        expect_retire(RESET_PC + 8, 1, 4, -32'd20);
        expect_retire(RESET_PC + 12, 1, 5, 32'h12345000 - 32'd20);
        execute("arith", 1'b0, RESET_PC + 16);

        // skipped slots hold undefined words
        prog.push_back(encode_jal(1, 21'd12));
        prog.push_back(BAD_WORD);
        prog.push_back(BAD_WORD);
        prog.push_back(encode_u(OPC_AUIPC, 6, 20'h0));
        prog.push_back(encode_i(OPC_JALR, 3'b000, 7, 6, 12'd13));
        prog.push_back(BAD_WORD);
        prog.push_back(EBREAK);
        expect_retire(RESET_PC, 1, 1, RESET_PC + 4);
        expect_retire(RESET_PC + 12, 1, 6, RESET_PC + 12);
        expect_retire(RESET_PC + 16, 1, 7, RESET_PC + 20);
        execute("jumps", 1'b0, RESET_PC + 24);

        prog.push_back(encode_u(OPC_LUI, 8, 20'ha1b2c));
        prog.push_back(encode_i(OPC_OP_IMM, 3'b000, 8, 8, 12'h3d4));
        prog.push_back(encode_i(OPC_OP_IMM, 3'b000, 9, 0, 12'd64));
        prog.push_back(encode_s(3'b010, 8, 9, 12'd0));
        prog.push_back(encode_i(OPC_LOAD, 3'b010, 10, 9, 12'd0));
        prog.push_back(encode_i(OPC_OP_IMM, 3'b000, 11, 0, 12'h05e));
        prog.push_back(encode_s(3'b000, 11, 9, 12'd2));
        prog.push_back(encode_i(OPC_LOAD, 3'b010, 12, 9, 12'd0));
        prog.push_back(encode_i(OPC_LOAD, 3'b100, 13, 9, 12'd3));
        prog.push_back(EBREAK);
        expect_retire(RESET_PC, 1, 8, 32'ha1b2c000);
        expect_retire(RESET_PC + 4, 1, 8, 32'ha1b2c3d4);
        expect_retire(RESET_PC + 8, 1, 9, 64);
        expect_retire(RESET_PC + 12, 0, 0, 0);
        expect_retire(RESET_PC + 16, 1, 10, 32'ha1b2c3d4);
        expect_retire(RESET_PC + 20, 1, 11, 32'h5e);
        expect_retire(RESET_PC + 24, 0, 0, 0);
        expect_retire(RESET_PC + 28, 1, 12, (32'ha1b2c3d4 & ~32'h00ff0000) | (32'h5e << 16));
        expect_retire(RESET_PC + 32, 1, 13, 32'h000000a1);
        execute("memory", 1'b0, RESET_PC + 36);

        prog.push_back(encode_i(OPC_OP_IMM, 3'b000, 0, 0, 12'd99));
        prog.push_back(encode_add(14, 0, 0));
        prog.push_back(EBREAK);
        expect_retire(RESET_PC, 1, 0, 99);
        expect_retire(RESET_PC + 4, 1, 14, 0);
        execute("x0_reg", 1'b0, RESET_PC + 8);

        prog.push_back(encode_i(OPC_OP_IMM, 3'b000, 15, 0, 12'd3));
        prog.push_back(BAD_WORD);
        expect_retire(RESET_PC, 1, 15, 3);
        execute("illegal", 1'b1, RESET_PC + 4);

        $display("%0d tests, %0d failed, %0d check errors, %0d assertion failures",
                 tests_run, tests_failed, total_errors, dut0.u_assertions.failures);
        if (total_errors == 0 && dut0.u_assertions.failures == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

/* build.f */
+incdir+design
design/npc_pkg.sv
design/npc_mem_if.sv
design/npc_inst_mem.sv
design/npc_decoder.sv
design/npc_regfile.sv
design/npc_lsu.sv
design/npc_data_mem.sv
design/npc_core.sv
design/npc_top.sv
sim/npc_assertions.sv
sim/npc_tb.sv

/* Makefile */
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -f build.f --top-module npc_tb -o npc_sim
	./obj_dir/npc_sim +verilator+error+limit+100 | tee sim.log
	grep -q "All checks passed" sim.log

clean:
	rm -rf obj_dir sim.log
